//--- verilog/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data word width in bits
`define RV_XLEN 32

// APB byte address width
`define RV_ADDR_BITS 32

// RAM depth in words for 4 KiB of address space
`define RV_MEM_WORDS 1024

// A set bit inserts one wait cycle into its transfer
`define RV_WAIT_PATTERN 8'b1001_0110

// First fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

//--- verilog/rv_pkg.sv
`default_nettype none
`include "rv_settings.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0]      word_t;
	typedef logic [`RV_ADDR_BITS-1:0] addr_t;
	typedef logic [4:0]               reg_idx_t;
	typedef logic [`RV_XLEN/8-1:0]    strobe_t;

	// Instruction bit 30 on top of funct3
	typedef logic [3:0] alu_op_t;

	typedef struct packed {
		addr_t   paddr;
		word_t   pwdata;
		strobe_t pstrb;
		logic    psel;
		logic    penable;
		logic    pwrite;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEM,
		WRITEBACK,
		HALT
	} core_state_t;

endpackage

`default_nettype wire

//--- verilog/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input  rv_pkg::alu_op_t op,
	input  rv_pkg::word_t   a,
	input  rv_pkg::word_t   b,
	output rv_pkg::word_t   result,
	output logic            cond_true
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic       eq;
	logic       lt_s;
	logic       lt_u;

	assign shamt = b[4:0];
	assign eq    = (a == b);
	assign lt_s  = ($signed(a) < $signed(b));
	assign lt_u  = (a < b);

	always_comb begin
		casez (op)
			4'b0000: result = a + b;
			4'b1000: result = a - b;
			4'b?001: result = a << shamt;
			4'b?010: result = word_t'(lt_s);
			4'b?011: result = word_t'(lt_u);
			4'b?100: result = a ^ b;
			4'b0101: result = a >> shamt;
			4'b1101: result = word_t'($signed(a) >>> shamt); // SRA and SRAI
			4'b?110: result = a | b;
			default: result = a & b;
		endcase
	end

	// Branch condition uses funct3 only
	always_comb begin
		case (op[2:0])
			3'b000:  cond_true = eq;    // BEQ
			3'b001:  cond_true = !eq;   // BNE
			3'b100:  cond_true = lt_s;  // BLT
			3'b101:  cond_true = !lt_s; // BGE
			3'b110:  cond_true = lt_u;  // BLTU
			3'b111:  cond_true = !lt_u; // BGEU
			default: cond_true = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::reg_idx_t ra0,
	input  rv_pkg::reg_idx_t ra1,
	output rv_pkg::word_t    rd0,
	output rv_pkg::word_t    rd1,
	input  logic             we,
	input  rv_pkg::reg_idx_t wa,
	input  rv_pkg::word_t    wd
);
	import rv_pkg::*;

	word_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != reg_idx_t'(0)) begin
			regs[wa] <= wd;
		end
	end

	assign rd0 = (ra0 == reg_idx_t'(0)) ? '0 : regs[ra0];
	assign rd1 = (ra1 == reg_idx_t'(0)) ? '0 : regs[ra1];

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_core (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             run,
	output rv_pkg::apb_req_t apb_req,
	input  rv_pkg::apb_rsp_t apb_rsp,
	output logic             halted,
	output logic             bus_error
);
	import rv_pkg::*;

	localparam logic [2:0] GRP_STORE  = 3'd0;
	localparam logic [2:0] GRP_LOAD   = 3'd1;
	localparam logic [2:0] GRP_UPPER  = 3'd2; // LUI and AUIPC
	localparam logic [2:0] GRP_ALU    = 3'd3;
	localparam logic [2:0] GRP_JAL    = 3'd4;
	localparam logic [2:0] GRP_JALR   = 3'd5;
	localparam logic [2:0] GRP_BRANCH = 3'd6;
	localparam logic [2:0] GRP_HALT   = 3'd7;

	core_state_t state;
	logic        started;
	logic        access_q;
	logic        bus_done;
	addr_t       pc;
	addr_t       pc_plus4;
	word_t       instr;
	logic [2:0]  group;
	logic [2:0]  group_q;
	logic [2:0]  funct3;
	addr_t       mem_addr;
	word_t       st_data;
	strobe_t     st_strb;
	word_t       load_q;
	word_t       load_lane;
	word_t       load_ext;
	word_t       rd0;
	word_t       rd1;
	word_t       imm_i;
	word_t       imm_s;
	word_t       imm_b;
	word_t       imm_j;
	word_t       imm_u;
	word_t       alu_b;
	word_t       alu_result;
	alu_op_t     alu_op;
	logic        alu_ex;
	logic        cond_true;
	logic        we;
	word_t       wd;

	assign funct3   = instr[14:12];
	assign pc_plus4 = pc + addr_t'(4);
	assign imm_i    = {{21{instr[31]}}, instr[30:20]};
	assign imm_s    = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign imm_b    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u    = {instr[31:12], 12'b0};

	always_comb begin
		casez (instr[6:0])
			7'b0100011: group = GRP_STORE;
			7'b0000011: group = GRP_LOAD;
			7'b0?10111: group = GRP_UPPER;
			7'b0?10011: group = GRP_ALU;
			7'b1101111: group = GRP_JAL;
			7'b1100111: group = GRP_JALR;
			7'b1100011: group = GRP_BRANCH;
			default:    group = GRP_HALT; // Includes the all-zero word
		endcase
	end

	// Bit 30 only matters for SRA/SRAI and register-register SUB/SRA
	assign alu_ex = (funct3 == 3'b101 || instr[6:0] == 7'b0110011) ? instr[30] : 1'b0;

	always_comb begin
		case (group_q)
			GRP_ALU:    alu_op = {alu_ex, funct3};
			GRP_BRANCH: alu_op = {1'b0, funct3};
			default:    alu_op = 4'b0000; // Address add
		endcase
	end

	assign alu_b = (group_q == GRP_STORE) ? imm_s :
		(instr[5] && group_q != GRP_JALR) ? rd1 : imm_i;

	rv_alu rv_alu_inst (
		.op        (alu_op),
		.a         (rd0),
		.b         (alu_b),
		.result    (alu_result),
		.cond_true (cond_true)
	);

	// Returned lane moved down to bit 0
	assign load_lane = load_q >> {mem_addr[1:0], 3'b000};

	always_comb begin
		case (funct3)
			3'b000:  load_ext = {{24{load_lane[7]}}, load_lane[7:0]};   // LB
			3'b001:  load_ext = {{16{load_lane[15]}}, load_lane[15:0]}; // LH
			3'b100:  load_ext = {24'b0, load_lane[7:0]};                // LBU
			3'b101:  load_ext = {16'b0, load_lane[15:0]};               // LHU
			default: load_ext = load_lane;
		endcase
	end

	always_comb begin
		we = 1'b0;
		wd = pc_plus4; // Link value
		if (state == WRITEBACK) begin
			we = 1'b1;
			wd = load_ext;
		end else if (state == EXECUTE) begin
			case (group_q)
				GRP_ALU: begin
					we = 1'b1;
					wd = alu_result;
				end
				GRP_UPPER: begin
					we = 1'b1;
					wd = instr[5] ? imm_u : pc + imm_u; // LUI else AUIPC
				end
				GRP_JAL,
				GRP_JALR: we = 1'b1;
				default: we = 1'b0;
			endcase
		end
	end

	rv_regfile rv_regfile_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.ra0   (instr[19:15]),
		.ra1   (instr[24:20]),
		.rd0   (rd0),
		.rd1   (rd1),
		.we    (we),
		.wa    (instr[11:7]),
		.wd    (wd)
	);

	// Setup cycle on entry to FETCH or MEM and access once access_q is set
	always_comb begin
		apb_req.psel    = (state == FETCH && started) || state == MEM;
		apb_req.penable = apb_req.psel && access_q;
		apb_req.pwrite  = (state == MEM && group_q == GRP_STORE);
		apb_req.paddr   = (state == MEM) ? mem_addr : pc;
		apb_req.pwdata  = st_data;
		apb_req.pstrb   = (state == MEM) ? st_strb : '1;
	end

	assign bus_done = apb_req.penable && apb_rsp.pready;
	assign halted   = (state == HALT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= FETCH;
			pc        <= `RV_RESET_PC;
			started   <= 1'b0;
			access_q  <= 1'b0;
			bus_error <= 1'b0;
		end else begin
			if (run) begin
				started <= 1'b1;
			end
			if (apb_req.psel && !access_q) begin
				access_q <= 1'b1;
			end else if (bus_done) begin
				access_q <= 1'b0;
			end
			case (state)
				FETCH: begin
					if (bus_done) begin
						if (apb_rsp.pslverr) begin
							bus_error <= 1'b1;
							state     <= HALT;
						end else begin
							state <= DECODE;
						end
					end
				end
				DECODE: state <= (group == GRP_HALT) ? HALT : EXECUTE;
				EXECUTE: begin
					pc    <= pc_plus4;
					state <= FETCH;
					case (group_q)
						GRP_JAL:  pc <= pc + imm_j;
						GRP_JALR: pc <= {alu_result[31:1], 1'b0};
						GRP_BRANCH: begin
							if (cond_true) begin
								pc <= pc + imm_b;
							end
						end
						GRP_LOAD,
						GRP_STORE: state <= MEM;
						default: state <= FETCH;
					endcase
				end
				MEM: begin
					if (bus_done) begin
						if (apb_rsp.pslverr) begin
							bus_error <= 1'b1;
							state     <= HALT;
						end else if (group_q == GRP_STORE) begin
							state <= FETCH; // Next fetch setup follows directly
						end else begin
							state <= WRITEBACK;
						end
					end
				end
				WRITEBACK: state <= FETCH;
				default: state <= HALT; // Held until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH && bus_done) begin
			instr <= apb_rsp.prdata;
		end
		if (state == DECODE) begin
			group_q <= group;
		end
		if (state == EXECUTE) begin
			mem_addr <= alu_result;
			if (group_q == GRP_LOAD) begin
				st_strb <= '1;
				st_data <= rd1;
			end else begin
				case (funct3[1:0])
					2'b00: begin
						st_strb <= strobe_t'(4'b0001) << alu_result[1:0];
						st_data <= {4{rd1[7:0]}}; // Byte on every lane
					end
					2'b01: begin
						st_strb <= strobe_t'(4'b0011) << {alu_result[1], 1'b0};
						st_data <= {2{rd1[15:0]}};
					end
					default: begin
						st_strb <= '1;
						st_data <= rd1;
					end
				endcase
			end
		end
		if (state == MEM && bus_done) begin
			load_q <= apb_rsp.prdata;
		end
	end

endmodule

`default_nettype wire

//--- verilog/apb_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module apb_ram (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::apb_req_t apb_req,
	output rv_pkg::apb_rsp_t apb_rsp,
	input  logic             load_we,
	input  rv_pkg::addr_t    load_addr,
	input  rv_pkg::word_t    load_data,
	input  rv_pkg::addr_t    peek_addr,
	output rv_pkg::word_t    peek_data
);
	import rv_pkg::*;

	localparam int IDX_BITS = $clog2(`RV_MEM_WORDS);
	localparam int LANES    = `RV_XLEN / 8;
	localparam addr_t MEM_BYTES = addr_t'(`RV_MEM_WORDS * 4);

	word_t               mem [`RV_MEM_WORDS];
	logic [IDX_BITS-1:0] bus_idx;
	logic                in_range;
	logic                access;
	logic                wait_now;
	logic                done;
	logic [7:0]          pattern_q; // Bit 0 applies to the current transfer
	logic                waited_q;

	assign bus_idx  = apb_req.paddr[IDX_BITS+1:2];
	assign in_range = (apb_req.paddr < MEM_BYTES);
	assign access   = apb_req.psel && apb_req.penable;
	assign wait_now = pattern_q[0] && !waited_q;
	assign done     = access && !wait_now;

	assign apb_rsp.prdata  = mem[bus_idx];
	assign apb_rsp.pready  = !wait_now;
	assign apb_rsp.pslverr = !in_range;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pattern_q <= `RV_WAIT_PATTERN;
			waited_q  <= 1'b0;
		end else if (done) begin
			pattern_q <= {pattern_q[0], pattern_q[7:1]}; // Rotate per transfer
			waited_q  <= 1'b0;
		end else if (access) begin
			waited_q <= 1'b1;
		end
	end

	// Backdoor loads only happen while the core is idle
	always_ff @(posedge clk) begin
		if (load_we && load_addr < MEM_BYTES) begin
			mem[load_addr[IDX_BITS+1:2]] <= load_data;
		end else if (done && apb_req.pwrite && in_range) begin
			for (int i = 0; i < LANES; i++) begin
				if (apb_req.pstrb[i]) begin
					mem[bus_idx][8*i +: 8] <= apb_req.pwdata[8*i +: 8];
				end
			end
		end
	end

	assign peek_data = mem[peek_addr[IDX_BITS+1:2]];

endmodule

`default_nettype wire

//--- verilog/rv_soc.sv
`timescale 1ns/1ps
`default_nettype none

module rv_soc (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          run,
	input  logic          load_we,
	input  rv_pkg::addr_t load_addr,
	input  rv_pkg::word_t load_data,
	input  rv_pkg::addr_t peek_addr,
	output rv_pkg::word_t peek_data,
	output logic          halted,
	output logic          bus_error
);
	import rv_pkg::*;

	apb_req_t apb_req; // Core to RAM
	apb_rsp_t apb_rsp;

	rv_core rv_core_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.halted    (halted),
		.bus_error (bus_error)
	);

	apb_ram apb_ram_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.peek_addr (peek_addr),
		.peek_data (peek_data)
	);

endmodule

`default_nettype wire

//--- verification/rv_soc_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv_soc_assert (
	input logic             clk,
	input logic             rst_n,
	input rv_pkg::apb_req_t apb_req,
	input rv_pkg::apb_rsp_t apb_rsp
);
	import rv_pkg::*;

	// Access phase only after a setup cycle
	setup_first: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(apb_req.penable) |-> $past(apb_req.psel))
		else $error("APB penable rose without a preceding setup cycle");

	hold_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.penable && !apb_rsp.pready |=> $stable(apb_req))
		else $error("APB request changed while pready was low");

	read_strobes: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.psel && !apb_req.pwrite |-> apb_req.pstrb == '1)
		else $error("APB read with pstrb not all ones");

endmodule

bind rv_core rv_soc_assert rv_soc_assert_inst (
	.clk     (clk),
	.rst_n   (rst_n),
	.apb_req (apb_req),
	.apb_rsp (apb_rsp)
);

`default_nettype wire

//--- verification/rv_soc_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_soc_tb;
	import rv_pkg::*;

	localparam int MEM_WORDS = `RV_MEM_WORDS;
	localparam int DUMP_BASE = 'h700; // Register dump area
	localparam int CPI_MAX   = 10;    // Fetch, decode, execute and one data transfer

	logic        clk;
	logic        rst_n;
	logic        run;
	logic        load_we;
	addr_t       load_addr;
	word_t       load_data;
	addr_t       peek_addr;
	word_t       peek_data;
	logic        halted;
	logic        bus_error;
	word_t       exp_mem [MEM_WORDS]; // Model memory
	logic        exp_err;
	logic [31:0] lfsr;
	int          plen;
	int unsigned cycles = 0;
	int unsigned cycle_limit = 0;

	rv_soc rv_soc_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.peek_addr (peek_addr),
		.peek_data (peek_data),
		.halted    (halted),
		.bus_error (bus_error)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the core did not halt within %0d cycles", cycle_limit);
			fail_now();
		end
	end

	task automatic fail_now();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("MISMATCH time=%0t %s got %h expected %h", $time, name, got, exp);
			fail_now();
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] rnd(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd,
			input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
			input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t enc_s(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_u(input int imm, input int rd, input logic [6:0] op);
		return {imm[19:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic gen_alu(input int i);
		int rd;
		int rs1;
		int f3;
		int imm;
		rd  = int'(rnd(5));
		rs1 = int'(rnd(5));
		f3  = int'(rnd(3));
		imm = int'(rnd(12));
		imm = (f3 == 1) ? imm & 31 : (f3 == 5) ? imm & 'h41f : imm; // Legal shift forms
		case (rnd(2))
			0: exp_mem[i] = enc_u(int'(rnd(20)), rd, 7'b0110111); // LUI
			1: exp_mem[i] = enc_u(int'(rnd(20)), rd, 7'b0010111); // AUIPC
			2: exp_mem[i] = enc_i(imm, rs1, f3, rd, 7'b0010011);
			default: exp_mem[i] = enc_r((f3 == 0 || f3 == 5) ? int'(rnd(1)) * 32 : 0,
				int'(rnd(5)), rs1, f3, rd);
		endcase
	endtask

	task automatic gen_mem(input int i);
		int sz;
		int off;
		int rd;
		int f3;
		sz  = int'(rnd(2)) % 3;
		off = 'h400 + (int'(rnd(7)) << sz); // Aligned to the access size
		rd  = int'(rnd(5));
		f3  = (sz < 2 && rnd(1) == 1) ? sz + 4 : sz;
		exp_mem[i] = rnd(1) ? enc_s(off, rd, 0, sz) : enc_i(off, 0, f3, rd, 7'b0000011);
	endtask

	task automatic gen_ctrl(input int i);
		int t;
		int rd;
		int f3;
		t  = i + 1 + int'(rnd(2)); // At most four words ahead
		rd = int'(rnd(5));
		f3 = int'(rnd(3));
		f3 = (f3 == 2 || f3 == 3) ? f3 + 4 : f3;
		case (rnd(2))
			0: exp_mem[i] = enc_j((t - i) * 4, rd);
			1: exp_mem[i] = enc_i(t * 4 + int'(rnd(1)), 0, 0, rd, 7'b1100111); // Bit 0 dropped
			default: exp_mem[i] = enc_b((t - i) * 4, int'(rnd(5)), int'(rnd(5)), f3);
		endcase
	endtask

	// Mode 0 ALU, 1 memory, 2 control flow, 3 memory ending in a bus error
	task automatic build_program(input int mode);
		int n;
		n    = 20 + int'(rnd(5));
		plen = n + 33;
		for (int i = 0; i < MEM_WORDS; i++) begin
			exp_mem[i] = (word_t'(i) * 32'h9e37_79b1) ^ 32'h5a3c_c3a5;
		end
		for (int i = 0; i < n; i++) begin
			if (mode == 0 || rnd(1) == 0) begin
				gen_alu(i);
			end else if (mode == 2) begin
				gen_ctrl(i);
			end else begin
				gen_mem(i);
			end
		end
		if (mode == 3) begin
			exp_mem[n - 2] = enc_u(int'(rnd(20)) | 1, 5, 7'b0110111); // x5 at or above 4 KiB
			exp_mem[n - 1] = rnd(1) ? enc_s(int'(rnd(7)) << 2, int'(rnd(5)), 5, 2)
				: enc_i(int'(rnd(7)) << 2, 5, 2, int'(rnd(5)), 7'b0000011);
		end
		for (int r = 0; r < 32; r++) begin
			exp_mem[n + r] = enc_s(DUMP_BASE + 4 * r, r, 0, 2);
		end
		exp_mem[n + 32] = '0; // Halt
	endtask

	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
			input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic word_t load_ref(input logic [2:0] f3, input word_t w, input int ofs);
		word_t lane;
		lane = w >> (ofs * 8);
		case (f3)
			3'd0: return {{24{lane[7]}}, lane[7:0]};
			3'd1: return {{16{lane[15]}}, lane[15:0]};
			3'd4: return {24'b0, lane[7:0]};
			3'd5: return {16'b0, lane[15:0]};
			default: return lane;
		endcase
	endfunction

	// Instruction-set model that runs the program in exp_mem until halt or bus error
	task automatic run_model();
		word_t       x [32];
		word_t       ins;
		word_t       a;
		word_t       b;
		word_t       imm;
		word_t       ea;
		word_t       v;
		logic [31:0] pc;
		logic [31:0] nxt;
		logic [2:0]  f3;
		int          lane;
		logic        wr;
		logic        stop;
		for (int r = 0; r < 32; r++) begin
			x[r] = '0;
		end
		pc      = `RV_RESET_PC;
		stop    = 1'b0;
		exp_err = 1'b0;
		while (!stop) begin
			ins  = exp_mem[pc[11:2]];
			f3   = ins[14:12];
			a    = x[ins[19:15]];
			b    = x[ins[24:20]];
			imm  = {{20{ins[31]}}, ins[31:20]};
			ea   = a + (ins[5] ? {{20{ins[31]}}, ins[31:25], ins[11:7]} : imm);
			lane = int'(ea[1:0]);
			wr   = 1'b1;
			v    = pc + 4; // Link value
			nxt  = pc + 4;
			case (ins[6:0])
				7'b0110111: v = {ins[31:12], 12'b0};
				7'b0010111: v = pc + {ins[31:12], 12'b0};
				7'b0010011: v = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm);
				7'b0110011: v = alu_ref(f3, ins[30], a, b);
				7'b1101111: nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				7'b1100111: nxt = (a + imm) & ~32'd1;
				7'b1100011: begin
					wr = 1'b0;
					if (branch_ref(f3, a, b)) begin
						nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
					end
				end
				7'b0000011,
				7'b0100011: begin
					if (ea >= MEM_WORDS * 4) begin
						exp_err = 1'b1; // Nothing retires
						stop    = 1'b1;
						wr      = 1'b0;
					end else if (!ins[5]) begin
						v = load_ref(f3, exp_mem[ea[11:2]], lane);
					end else begin
						wr = 1'b0;
						case (f3)
							3'd0: exp_mem[ea[11:2]][lane * 8 +: 8] = b[7:0];
							3'd1: exp_mem[ea[11:2]][(lane / 2) * 16 +: 16] = b[15:0];
							default: exp_mem[ea[11:2]] = b;
						endcase
					end
				end
				default: begin
					wr   = 1'b0;
					stop = 1'b1;
				end
			endcase
			if (wr && ins[11:7] != 5'd0) begin
				x[ins[11:7]] = v;
			end
			pc = nxt;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		run   <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic load_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			@(posedge clk);
			load_we   <= 1'b1;
			load_addr <= addr_t'(i * 4);
			load_data <= exp_mem[i];
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	task automatic compare_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			@(posedge clk);
			peek_addr <= addr_t'(i * 4);
			@(negedge clk);
			check_value($sformatf("peek_data @%0h", i * 4), peek_data, exp_mem[i]);
		end
	endtask

	initial begin
		rst_n     = 1'b0;
		run       = 1'b0;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		peek_addr = '0;
		lfsr      = 32'h65fd29f0;
		for (int p = 0; p < 12; p++) begin
			build_program(p % 4);
			cycle_limit = cycle_limit + 16 + 3 * MEM_WORDS + CPI_MAX * plen + 64;
			apply_reset();
			load_memory();
			@(negedge clk);
			check_value("halted", word_t'(halted), '0);
			check_value("bus_error", word_t'(bus_error), '0);
			compare_memory(); // Loaded image unchanged before run
			run_model();
			@(posedge clk);
			run <= 1'b1;
			@(negedge clk);
			while (!halted) begin
				@(negedge clk);
			end
			check_value("bus_error", word_t'(bus_error), word_t'(exp_err));
			compare_memory();
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_core.sv
verilog/apb_ram.sv
verilog/rv_soc.sv
verification/rv_soc_assert.sv
verification/rv_soc_tb.sv

//--- Makefile
SIM = obj_dir/rv_soc_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module rv_soc_tb \
		-Mdir obj_dir -o rv_soc_sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
